// File: hw/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    localparam int data_width = 8;
    localparam int addr_width = 16;
    localparam int psr_width  = 7;

    localparam int carry_flag    = 0;   // Positions in the 8-bit status word
    localparam int zero_flag     = 1;
    localparam int overflow_flag = 6;
    localparam int negative_flag = 7;

    // Write and read masks are psr_width wide, status bit 5 is not carried
    localparam logic [psr_width-1:0] carry_mask    = psr_width'(1) << carry_flag;
    localparam logic [psr_width-1:0] zero_mask     = psr_width'(1) << zero_flag;
    localparam logic [psr_width-1:0] overflow_mask = psr_width'(1) << (overflow_flag - 1);
    localparam logic [psr_width-1:0] negative_mask = psr_width'(1) << (negative_flag - 1);
    localparam logic [psr_width-1:0] nz_mask       = zero_mask | negative_mask;
    localparam logic [psr_width-1:0] cnz_mask      = nz_mask | carry_mask;

    typedef enum logic [1:0] {
        buf_idle  = 2'b00,
        buf_load  = 2'b01,
        buf_store = 2'b10
    } buf_ctl_e;

    typedef enum logic [2:0] {
        reg_idle       = 3'b000,
        reg_load_bus1  = 3'b100,   // Enable, store, bus 2
        reg_store_bus1 = 3'b110,
        reg_load_bus2  = 3'b101,
        reg_store_bus2 = 3'b111
    } reg_ctl_e;

    typedef enum logic [2:0] {
        pc_hold   = 3'b000,
        pc_inc    = 3'b001,
        pc_branch = 3'b011,
        pc_load   = 3'b100
    } pc_ctl_e;

    typedef enum logic [4:0] {
        alu_nop, alu_asl, alu_lsr, alu_rol, alu_ror,
        alu_and, alu_or, alu_xor, alu_add, alu_sub,
        alu_cmp, alu_inc, alu_dec, alu_flg, alu_tmx
    } alu_op_e;

    typedef enum logic [1:0] {
        sel_pc      = 2'd0,
        sel_operand = 2'd1
    } addr_sel_e;

    typedef enum logic [3:0] {
        s_idle, s_opcode_read, s_zpg_adr_read, s_idl_data_write,
        s_alu_final, s_alu_tmx, s_dbuf_output, s_abs_lb,
        s_abs_hb, s_pc_load, s_branch_check
    } state_e;

    typedef struct packed {
        logic [psr_width-1:0]  psr_write;
        logic [data_width-1:0] psr_value;
        logic                  psr_rw;
        logic [addr_width-1:0] memory_address;
        addr_sel_e             address_select;
        logic                  rw;           // 1 read, 0 write
        buf_ctl_e              data_buffer;
        buf_ctl_e              input_latch;
        pc_ctl_e               pc;
        alu_op_e               alu;
        reg_ctl_e              acc;
        reg_ctl_e              x;
        reg_ctl_e              y;
    } ctrl_bundle_t;

endpackage

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    import cpu_ctrl_pkg::*;

    typedef enum logic [7:0] {
        op_nop     = 8'hEA,
        op_sec     = 8'h38, op_clc     = 8'h18, op_clv     = 8'hB8,
        op_tax     = 8'hAA, op_tay     = 8'hA8, op_txa     = 8'h8A, op_tya = 8'h98,
        op_inx     = 8'hE8, op_iny     = 8'hC8, op_dex     = 8'hCA, op_dey = 8'h88,
        op_asl_a   = 8'h0A, op_lsr_a   = 8'h4A, op_rol_a   = 8'h2A, op_ror_a = 8'h6A,
        op_lda_imm = 8'hA9, op_lda_zpg = 8'hA5, op_lda_abs = 8'hAD,
        op_ldx_imm = 8'hA2, op_ldx_zpg = 8'hA6, op_ldx_abs = 8'hAE,
        op_ldy_imm = 8'hA0, op_ldy_zpg = 8'hA4, op_ldy_abs = 8'hAC,
        op_ora_imm = 8'h09, op_ora_zpg = 8'h05, op_ora_abs = 8'h0D,
        op_and_imm = 8'h29, op_and_zpg = 8'h25, op_and_abs = 8'h2D,
        op_eor_imm = 8'h49, op_eor_zpg = 8'h45, op_eor_abs = 8'h4D,
        op_adc_imm = 8'h69, op_adc_zpg = 8'h65, op_adc_abs = 8'h6D,
        op_sbc_imm = 8'hE9, op_sbc_zpg = 8'hE5, op_sbc_abs = 8'hED,
        op_cmp_imm = 8'hC9, op_cmp_zpg = 8'hC5, op_cmp_abs = 8'hCD,
        op_cpx_imm = 8'hE0, op_cpx_zpg = 8'hE4, op_cpx_abs = 8'hEC,
        op_cpy_imm = 8'hC0, op_cpy_zpg = 8'hC4, op_cpy_abs = 8'hCC,
        op_sta_zpg = 8'h85, op_sta_abs = 8'h8D,
        op_stx_zpg = 8'h86, op_stx_abs = 8'h8E,
        op_sty_zpg = 8'h84, op_sty_abs = 8'h8C,
        op_bpl     = 8'h10, op_bmi     = 8'h30, op_bcc     = 8'h90,
        op_bcs     = 8'hB0, op_bne     = 8'hD0, op_beq     = 8'hF0,
        op_jmp_abs = 8'h4C
    } opcode_e;

    typedef enum logic [2:0] {
        mode_implied, mode_acc, mode_imm, mode_zpg, mode_abs, mode_rel
    } addr_mode_e;

    typedef enum logic [3:0] {
        kind_nop, kind_flag, kind_transfer, kind_step, kind_shift, kind_load,
        kind_store, kind_alu, kind_compare, kind_branch, kind_jump
    } insn_kind_e;

    typedef enum logic [1:0] {
        reg_none, reg_a, reg_x, reg_y
    } reg_id_e;

    // Same as opcode bits 7:5 of the branch instructions
    typedef enum logic [2:0] {
        cond_pl = 3'b000,
        cond_mi = 3'b001,
        cond_cc = 3'b100,
        cond_cs = 3'b101,
        cond_ne = 3'b110,
        cond_eq = 3'b111
    } branch_cond_e;

    typedef struct packed {
        addr_mode_e           mode;
        insn_kind_e           kind;
        alu_op_e              alu_op;
        reg_id_e              target;
        reg_id_e              source;
        logic [psr_width-1:0] flag_mask;
        logic                 flag_set;
        branch_cond_e         cond;
    } decoded_t;

    localparam decoded_t nop_decode = '{
        mode:      mode_implied,
        kind:      kind_nop,
        alu_op:    alu_nop,
        target:    reg_none,
        source:    reg_none,
        flag_mask: '0,
        flag_set:  1'b0,
        cond:      cond_pl
    };

endpackage

`default_nettype wire

// File: hw/opcode_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module opcode_classifier import cpu_ctrl_pkg::*, isa_pkg::*; (
    input  logic [data_width-1:0] opcode,
    output decoded_t              decoded
);

    // Register field in bits 1:0 of loads and stores
    function automatic reg_id_e reg_field(logic [1:0] bits);
        case (bits)
            2'b01:   return reg_a;
            2'b10:   return reg_x;
            default: return reg_y;
        endcase
    endfunction

    always_comb begin
        decoded = nop_decode;
        case (opcode_e'(opcode))
            op_sec, op_clc: begin
                decoded.kind      = kind_flag;
                decoded.flag_mask = carry_mask;
                decoded.flag_set  = opcode[5];   // 38 sets, 18 clears
            end
            op_clv: begin
                decoded.kind      = kind_flag;
                decoded.flag_mask = overflow_mask;
            end
            op_tax, op_tay: begin
                decoded.kind   = kind_transfer;
                decoded.source = reg_a;
                decoded.target = opcode[1] ? reg_x : reg_y;
            end
            op_txa, op_tya: begin
                decoded.kind   = kind_transfer;
                decoded.target = reg_a;
                decoded.source = opcode[4] ? reg_y : reg_x;
            end
            op_inx, op_iny, op_dex, op_dey: begin
                decoded.kind      = kind_step;
                decoded.target    = (opcode == op_inx || opcode == op_dex) ? reg_x : reg_y;
                decoded.source    = decoded.target;
                decoded.alu_op    = (opcode == op_inx || opcode == op_iny) ? alu_inc : alu_dec;
                decoded.flag_mask = nz_mask;
            end
            op_asl_a, op_lsr_a, op_rol_a, op_ror_a: begin
                decoded.kind      = kind_shift;
                decoded.mode      = mode_acc;
                decoded.target    = reg_a;
                decoded.source    = reg_a;
                decoded.flag_mask = cnz_mask;
                decoded.alu_op    = opcode == op_asl_a ? alu_asl :
                                    opcode == op_lsr_a ? alu_lsr :
                                    opcode == op_rol_a ? alu_rol : alu_ror;
            end
            op_lda_imm, op_lda_zpg, op_lda_abs, op_ldx_imm, op_ldx_zpg, op_ldx_abs,
            op_ldy_imm, op_ldy_zpg, op_ldy_abs: begin
                decoded.kind      = kind_load;
                decoded.target    = reg_field(opcode[1:0]);
                decoded.alu_op    = alu_flg;
                decoded.flag_mask = nz_mask;
            end
            op_sta_zpg, op_sta_abs, op_stx_zpg, op_stx_abs, op_sty_zpg, op_sty_abs: begin
                decoded.kind   = kind_store;
                decoded.source = reg_field(opcode[1:0]);
            end
            op_ora_imm, op_ora_zpg, op_ora_abs, op_and_imm, op_and_zpg, op_and_abs,
            op_eor_imm, op_eor_zpg, op_eor_abs, op_adc_imm, op_adc_zpg, op_adc_abs,
            op_sbc_imm, op_sbc_zpg, op_sbc_abs: begin
                decoded.kind      = kind_alu;
                decoded.target    = reg_a;
                decoded.source    = reg_a;
                decoded.flag_mask = nz_mask;
                decoded.alu_op    = opcode[7:5] == 3'd0 ? alu_or  :
                                    opcode[7:5] == 3'd1 ? alu_and :
                                    opcode[7:5] == 3'd2 ? alu_xor :
                                    opcode[7:5] == 3'd3 ? alu_add : alu_sub;
            end
            op_cmp_imm, op_cmp_zpg, op_cmp_abs, op_cpx_imm, op_cpx_zpg, op_cpx_abs,
            op_cpy_imm, op_cpy_zpg, op_cpy_abs: begin
                decoded.kind      = kind_compare;
                decoded.source    = opcode[5] ? reg_x : (opcode[0] ? reg_a : reg_y);
                decoded.alu_op    = alu_cmp;
                decoded.flag_mask = cnz_mask;
            end
            op_bpl, op_bmi, op_bcc, op_bcs, op_bne, op_beq: begin
                decoded.kind = kind_branch;
                decoded.mode = mode_rel;
                decoded.cond = branch_cond_e'(opcode[7:5]);
            end
            op_jmp_abs: begin
                decoded.kind = kind_jump;
                decoded.mode = mode_abs;
            end
            default: ;   // Unsupported bytes run as NOP
        endcase
        // Memory operands take the mode from the 6502 column bits
        if (decoded.kind inside {kind_load, kind_store, kind_alu, kind_compare})
            decoded.mode = opcode[4:2] == 3'b001 ? mode_zpg :
                           opcode[4:2] == 3'b011 ? mode_abs : mode_imm;
    end

endmodule

`default_nettype wire

// File: hw/operand_latch.sv
`timescale 1ns/10ps
`default_nettype none

module operand_latch import cpu_ctrl_pkg::*, isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_enable,
    input  logic [data_width-1:0] instruction,
    input  state_e                next_state,
    input  decoded_t              decoded_now,
    output decoded_t              decoded,
    output logic [data_width-1:0] opcode_q,
    output logic [addr_width-1:0] operand_address
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decoded         <= nop_decode;
            opcode_q        <= op_nop;
            operand_address <= '0;
        end else if (clk_enable) begin
            if (next_state == s_opcode_read) begin
                decoded  <= decoded_now;
                opcode_q <= instruction;
            end
            if (next_state == s_zpg_adr_read || next_state == s_abs_lb)
                operand_address <= {{(addr_width - data_width){1'b0}}, instruction};
            else if (next_state == s_abs_hb || next_state == s_pc_load)
                operand_address <= {instruction, operand_address[data_width-1:0]};
        end
    end

endmodule

`default_nettype wire

// File: hw/microcode_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module microcode_sequencer import cpu_ctrl_pkg::*, isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clk_enable,
    input  decoded_t decoded_read,
    input  decoded_t decoded,
    output state_e   state,
    output state_e   next_state
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= s_idle;
        else if (clk_enable)
            state <= next_state;
    end

    always_comb begin
        next_state = s_idle;
        case (state)
            s_idle: next_state = s_opcode_read;
            s_opcode_read: begin
                if (decoded_read.kind == kind_step || decoded_read.kind == kind_shift)
                    next_state = s_alu_final;   // Register operand, no fetch
                else begin
                    case (decoded_read.mode)
                        mode_imm, mode_rel: next_state = s_idl_data_write;
                        mode_zpg:           next_state = s_zpg_adr_read;
                        mode_abs:           next_state = s_abs_lb;
                        default:            next_state = s_idle;
                    endcase
                end
            end
            s_zpg_adr_read, s_abs_hb: next_state = s_idl_data_write;
            s_idl_data_write:
                next_state = (decoded.mode == mode_rel) ? s_branch_check : s_alu_final;
            s_alu_final: next_state = s_alu_tmx;
            s_alu_tmx:
                next_state = (decoded.kind == kind_store) ? s_dbuf_output : s_idle;
            s_abs_lb:
                next_state = (decoded.kind == kind_jump) ? s_pc_load : s_abs_hb;
            default: next_state = s_idle;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/control_generator.sv
`timescale 1ns/10ps
`default_nettype none

module control_generator import cpu_ctrl_pkg::*, isa_pkg::*; (
    input  state_e                state,
    input  decoded_t              decoded_read,
    input  decoded_t              decoded,
    input  logic [addr_width-1:0] operand_address,
    input  logic [psr_width-1:0]  status_read,
    output ctrl_bundle_t          ctrl
);

    decoded_t d;
    reg_ctl_e src_ctl;
    reg_ctl_e tgt_ctl;
    logic     taken;

    // Source strobe wins when a register is both source and target
    function automatic reg_ctl_e reg_drive(reg_id_e id, reg_id_e src, reg_id_e tgt,
                                           reg_ctl_e s, reg_ctl_e t);
        if (src == id && s != reg_idle)
            return s;
        if (tgt == id)
            return t;
        return reg_idle;
    endfunction

    always_comb begin
        case (decoded.cond)
            cond_cc: taken = ~|(status_read & carry_mask);
            cond_cs: taken =  |(status_read & carry_mask);
            cond_ne: taken = ~|(status_read & zero_mask);
            cond_eq: taken =  |(status_read & zero_mask);
            cond_pl: taken = ~|(status_read & negative_mask);
            cond_mi: taken =  |(status_read & negative_mask);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        d           = (state == s_opcode_read) ? decoded_read : decoded;
        ctrl        = '0;
        ctrl.rw     = 1'b1;
        ctrl.psr_rw = 1'b1;
        src_ctl     = reg_idle;
        tgt_ctl     = reg_idle;
        case (state)
            s_opcode_read: begin
                ctrl.pc = pc_inc;
                if (d.kind == kind_flag) begin
                    ctrl.psr_write               = d.flag_mask;
                    ctrl.psr_value[data_width-1] = 1'b1;   // Marks an explicit flag write
                    if (d.flag_mask == carry_mask)
                        ctrl.psr_value[carry_flag] = d.flag_set;
                    else
                        ctrl.psr_value[overflow_flag] = d.flag_set;
                end else if (d.kind == kind_transfer) begin
                    src_ctl = reg_store_bus1;
                    tgt_ctl = reg_load_bus1;
                end
            end
            s_zpg_adr_read, s_abs_hb: begin
                ctrl.pc             = pc_inc;
                ctrl.address_select = sel_operand;
                ctrl.memory_address = operand_address;
            end
            s_abs_lb: ctrl.pc = pc_inc;
            s_idl_data_write: begin
                ctrl.input_latch = buf_load;
                if (d.mode == mode_imm)
                    ctrl.pc = pc_inc;   // Skip over the immediate byte
            end
            s_alu_final: begin
                ctrl.alu = d.alu_op;
                if (d.kind == kind_step || d.kind == kind_shift)
                    src_ctl = reg_store_bus1;
                else if (d.kind != kind_store) begin
                    ctrl.input_latch = buf_store;
                    src_ctl          = reg_store_bus2;
                end
            end
            s_alu_tmx: begin
                ctrl.psr_rw    = 1'b0;
                ctrl.psr_write = d.flag_mask;
                if (d.kind == kind_store) begin
                    ctrl.data_buffer = buf_load;
                    src_ctl          = reg_store_bus2;
                end else begin
                    ctrl.alu = alu_tmx;
                    tgt_ctl  = reg_load_bus2;
                end
            end
            s_dbuf_output: begin
                ctrl.data_buffer    = buf_store;
                ctrl.rw             = 1'b0;
                ctrl.address_select = sel_operand;
                ctrl.memory_address = operand_address;
            end
            s_pc_load: begin
                ctrl.pc             = pc_load;
                ctrl.memory_address = operand_address;
            end
            s_branch_check: begin
                if (taken) begin
                    ctrl.pc          = pc_branch;
                    ctrl.input_latch = buf_store;   // Offset onto the bus
                end
            end
            default: ;
        endcase
        ctrl.acc = reg_drive(reg_a, d.source, d.target, src_ctl, tgt_ctl);
        ctrl.x   = reg_drive(reg_x, d.source, d.target, src_ctl, tgt_ctl);
        ctrl.y   = reg_drive(reg_y, d.source, d.target, src_ctl, tgt_ctl);
    end

endmodule

`default_nettype wire

// File: hw/instruction_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instruction_decode import cpu_ctrl_pkg::*, isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_enable,
    input  logic [data_width-1:0] instruction,
    input  logic [psr_width-1:0]  status_read,
    output ctrl_bundle_t          ctrl
);

    decoded_t              decoded_now;
    decoded_t              decoded_read;
    decoded_t              decoded;
    logic [data_width-1:0] opcode_q;
    logic [addr_width-1:0] operand_address;
    state_e                state;
    state_e                next_state;

    opcode_classifier i_classify_now (
        .opcode  (instruction),
        .decoded (decoded_now)
    );

    opcode_classifier i_classify_read (   // Registered opcode, used in s_opcode_read
        .opcode  (opcode_q),
        .decoded (decoded_read)
    );

    operand_latch i_operand_latch (
        .clk             (clk),
        .rst_n           (rst_n),
        .clk_enable      (clk_enable),
        .instruction     (instruction),
        .next_state      (next_state),
        .decoded_now     (decoded_now),
        .decoded         (decoded),
        .opcode_q        (opcode_q),
        .operand_address (operand_address)
    );

    microcode_sequencer i_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_enable   (clk_enable),
        .decoded_read (decoded_read),
        .decoded      (decoded),
        .state        (state),
        .next_state   (next_state)
    );

    control_generator i_control (
        .state           (state),
        .decoded_read    (decoded_read),
        .decoded         (decoded),
        .operand_address (operand_address),
        .status_read     (status_read),
        .ctrl            (ctrl)
    );

endmodule

`default_nettype wire

// File: testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// kind: 0 implied, 1 through the ALU states, 2 jump, 3 branch
// amode: 0 no address, 1 zero page, 2 absolute
typedef struct packed {
    logic [7:0] opcode;
    logic [6:0] status;
    logic [3:0] cycles;
    logic [1:0] kind;
    logic [1:0] amode;
    logic       store;
    logic       stall;
    alu_op_e    alu;
    reg_ctl_e   acc;
    reg_ctl_e   x;
    reg_ctl_e   y;
    logic [6:0] psr_write;
    logic [7:0] psr_value;
    pc_ctl_e    pc;
} vec_t;

localparam int num_rows = 39;

// opcode status cyc kind amode store stall alu acc x y psr_write psr_value pc
localparam vec_t vectors [num_rows] = '{
    '{8'hEA, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_inc},
    '{8'h38, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h01, 8'h81, pc_inc},
    '{8'h18, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h01, 8'h80, pc_inc},
    '{8'hB8, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h20, 8'h80, pc_inc},
    '{8'hAA, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_store_bus1, reg_load_bus1, reg_idle, 7'h00, 8'h00, pc_inc},
    '{8'hA8, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_store_bus1, reg_idle, reg_load_bus1, 7'h00, 8'h00, pc_inc},
    '{8'h8A, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_load_bus1, reg_store_bus1, reg_idle, 7'h00, 8'h00, pc_inc},
    '{8'h98, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_load_bus1, reg_idle, reg_store_bus1, 7'h00, 8'h00, pc_inc},
    '{8'hE8, 7'h00, 4'd4, 2'd1, 2'd0, 1'b0, 1'b0, alu_inc, reg_idle, reg_load_bus2, reg_idle, 7'h42, 8'h00, pc_hold},
    '{8'h88, 7'h00, 4'd4, 2'd1, 2'd0, 1'b0, 1'b0, alu_dec, reg_idle, reg_idle, reg_load_bus2, 7'h42, 8'h00, pc_hold},
    '{8'h0A, 7'h00, 4'd4, 2'd1, 2'd0, 1'b0, 1'b0, alu_asl, reg_load_bus2, reg_idle, reg_idle, 7'h43, 8'h00, pc_hold},
    '{8'h6A, 7'h00, 4'd4, 2'd1, 2'd0, 1'b0, 1'b0, alu_ror, reg_load_bus2, reg_idle, reg_idle, 7'h43, 8'h00, pc_hold},
    '{8'hA9, 7'h00, 4'd5, 2'd1, 2'd0, 1'b0, 1'b0, alu_flg, reg_load_bus2, reg_idle, reg_idle, 7'h42, 8'h00, pc_hold},
    '{8'h09, 7'h00, 4'd5, 2'd1, 2'd0, 1'b0, 1'b0, alu_or, reg_load_bus2, reg_idle, reg_idle, 7'h42, 8'h00, pc_hold},
    '{8'hE9, 7'h00, 4'd5, 2'd1, 2'd0, 1'b0, 1'b0, alu_sub, reg_load_bus2, reg_idle, reg_idle, 7'h42, 8'h00, pc_hold},
    '{8'hC9, 7'h00, 4'd5, 2'd1, 2'd0, 1'b0, 1'b0, alu_cmp, reg_idle, reg_idle, reg_idle, 7'h43, 8'h00, pc_hold},
    '{8'hA6, 7'h00, 4'd6, 2'd1, 2'd1, 1'b0, 1'b0, alu_flg, reg_idle, reg_load_bus2, reg_idle, 7'h42, 8'h00, pc_hold},
    '{8'h25, 7'h00, 4'd6, 2'd1, 2'd1, 1'b0, 1'b0, alu_and, reg_load_bus2, reg_idle, reg_idle, 7'h42, 8'h00, pc_hold},
    '{8'hC4, 7'h00, 4'd6, 2'd1, 2'd1, 1'b0, 1'b0, alu_cmp, reg_idle, reg_idle, reg_idle, 7'h43, 8'h00, pc_hold},
    '{8'h85, 7'h00, 4'd7, 2'd1, 2'd1, 1'b1, 1'b0, alu_nop, reg_store_bus2, reg_idle, reg_idle, 7'h00, 8'h00, pc_hold},
    '{8'hAC, 7'h00, 4'd7, 2'd1, 2'd2, 1'b0, 1'b1, alu_flg, reg_idle, reg_idle, reg_load_bus2, 7'h42, 8'h00, pc_hold},
    '{8'h4D, 7'h00, 4'd7, 2'd1, 2'd2, 1'b0, 1'b0, alu_xor, reg_load_bus2, reg_idle, reg_idle, 7'h42, 8'h00, pc_hold},
    '{8'h6D, 7'h00, 4'd7, 2'd1, 2'd2, 1'b0, 1'b0, alu_add, reg_load_bus2, reg_idle, reg_idle, 7'h42, 8'h00, pc_hold},
    '{8'h8E, 7'h00, 4'd8, 2'd1, 2'd2, 1'b1, 1'b0, alu_nop, reg_idle, reg_store_bus2, reg_idle, 7'h00, 8'h00, pc_hold},
    '{8'h84, 7'h00, 4'd7, 2'd1, 2'd1, 1'b1, 1'b0, alu_nop, reg_idle, reg_idle, reg_store_bus2, 7'h00, 8'h00, pc_hold},
    '{8'h4C, 7'h00, 4'd4, 2'd2, 2'd2, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_load},
    '{8'h10, 7'h00, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_branch},
    '{8'h10, 7'h40, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_hold},
    '{8'h30, 7'h40, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_branch},
    '{8'h30, 7'h00, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_hold},
    '{8'h90, 7'h00, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_branch},
    '{8'h90, 7'h01, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_hold},
    '{8'hB0, 7'h01, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_branch},
    '{8'hB0, 7'h00, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_hold},
    '{8'hD0, 7'h00, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_branch},
    '{8'hD0, 7'h02, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_hold},
    '{8'hF0, 7'h02, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_branch},
    '{8'hF0, 7'h00, 4'd4, 2'd3, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_hold},
    '{8'hEA, 7'h00, 4'd2, 2'd0, 2'd0, 1'b0, 1'b0, alu_nop, reg_idle, reg_idle, reg_idle, 7'h00, 8'h00, pc_inc}
};

`endif

// File: testbench/tb_instruction_decode.sv
`timescale 1ns/10ps
`default_nettype none

module tb_instruction_decode import cpu_ctrl_pkg::*; ();

    `include "tb_vectors.svh"

    logic         clk;
    logic         rst_n;
    logic         clk_enable;
    logic [7:0]   instruction;
    logic [6:0]   status_read;
    ctrl_bundle_t ctrl;
    logic [31:0]  lcg_state;

    instruction_decode i_instruction_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_enable  (clk_enable),
        .instruction (instruction),
        .status_read (status_read),
        .ctrl        (ctrl)
    );

    always #50 clk = ~clk;

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // No strobes, read access and address 0 in s_idle
    task automatic check_idle();
        ctrl_bundle_t idle;
        idle        = '0;
        idle.rw     = 1'b1;
        idle.psr_rw = 1'b1;
        check_value("ctrl (idle)", 64'(idle), 64'(ctrl));
    endtask

    task automatic check_regs(input vec_t v);
        check_value("ctrl.acc", 64'(v.acc), 64'(ctrl.acc));
        check_value("ctrl.x", 64'(v.x), 64'(ctrl.x));
        check_value("ctrl.y", 64'(v.y), 64'(ctrl.y));
    endtask

    task automatic check_cycle(input vec_t v, input int k, input logic [15:0] addr);
        int alu_k;
        alu_k = v.store ? int'(v.cycles) - 3 : int'(v.cycles) - 2;
        if (k == 0)
            check_idle();
        if (k == 1)
            check_value("ctrl.pc", 64'(pc_inc), 64'(ctrl.pc));   // Fetch cycle always steps the PC
        if (v.kind == 2'd0 && k == 1) begin
            check_value("ctrl.psr_write", 64'(v.psr_write), 64'(ctrl.psr_write));
            check_value("ctrl.psr_value", 64'(v.psr_value), 64'(ctrl.psr_value));
            check_regs(v);
        end
        if (v.kind == 2'd1) begin
            if (k == alu_k)
                check_value("ctrl.alu", 64'(v.alu), 64'(ctrl.alu));
            if (k == alu_k + 1) begin
                check_value("ctrl.psr_rw", 64'(1'b0), 64'(ctrl.psr_rw));
                check_value("ctrl.psr_write", 64'(v.psr_write), 64'(ctrl.psr_write));
                check_value("ctrl.pc", 64'(v.pc), 64'(ctrl.pc));
                if (!v.store)
                    check_value("ctrl.alu", 64'(alu_tmx), 64'(ctrl.alu));
                check_regs(v);
            end
            if (v.amode != 2'd0 && k == int'(v.amode) + 1) begin   // zpg_adr_read or abs_hb
                check_value("ctrl.address_select", 64'(sel_operand), 64'(ctrl.address_select));
                check_value("ctrl.memory_address", 64'(addr), 64'(ctrl.memory_address));
            end
            if (v.store && k == int'(v.cycles) - 1) begin
                check_value("ctrl.rw", 64'(1'b0), 64'(ctrl.rw));
                check_value("ctrl.address_select", 64'(sel_operand), 64'(ctrl.address_select));
                check_value("ctrl.memory_address", 64'(addr), 64'(ctrl.memory_address));
            end
        end
        if (v.kind == 2'd2 && k == 3) begin
            check_value("ctrl.pc", 64'(v.pc), 64'(ctrl.pc));
            check_value("ctrl.memory_address", 64'(addr), 64'(ctrl.memory_address));
        end
        if (v.kind == 2'd3 && k == 3) begin
            check_value("ctrl.pc", 64'(v.pc), 64'(ctrl.pc));
            check_value("ctrl.input_latch", 64'(v.pc == pc_branch ? buf_store : buf_idle),
                        64'(ctrl.input_latch));
        end
    endtask

    // Holds clk_enable low over three more edges
    task automatic hold_and_compare();
        ctrl_bundle_t snap;
        int           s;
        snap = ctrl;
        for (s = 0; s < 3; s++) begin
            @(posedge clk);
            #5;
            if (s == 2)
                clk_enable = 1'b1;
            @(negedge clk);
            check_value("ctrl (clk_enable low)", 64'(snap), 64'(ctrl));
        end
    endtask

    initial begin
        vec_t        v;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [15:0] addr;
        int          r;
        int          k;
        clk         = 1'b0;
        rst_n       = 1'b0;
        clk_enable  = 1'b1;
        instruction = 8'hEA;
        status_read = 7'h00;
        lcg_state   = 32'd39038;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (r = 0; r < num_rows; r++) begin
            v    = vectors[r];
            lo   = lcg_byte();
            hi   = lcg_byte();
            addr = (v.amode == 2'd1) ? {8'h00, lo} : {hi, lo};
            for (k = 0; k < int'(v.cycles); k++) begin
                status_read = v.status;
                if (k == 0)
                    instruction = v.opcode;
                else if (k == 1)
                    instruction = lo;
                else if (k == 2)
                    instruction = hi;
                else
                    instruction = lcg_byte();   // Not captured in later states
                if (v.stall && k == 3)
                    clk_enable = 1'b0;
                @(negedge clk);
                check_cycle(v, k, addr);
                if (v.stall && k == 3)
                    hold_and_compare();
                @(posedge clk);
                #5;
            end
        end
        @(negedge clk);
        check_idle();
        $display("TEST OK");
        $finish;
    end

    initial begin
        #((num_rows * 10 + 20) * 100);
        $display("Simulation timed out before all instructions were played");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+testbench
hw/cpu_ctrl_pkg.sv
hw/isa_pkg.sv
hw/opcode_classifier.sv
hw/operand_latch.sv
hw/microcode_sequencer.sv
hw/control_generator.sv
hw/instruction_decode.sv
testbench/tb_instruction_decode.sv

// File: run.sh
#!/bin/sh
# Build the simulation with Verilator and run it; the exit status is the result
verilator --binary --timing -f verilog.f --top-module tb_instruction_decode -o tb_sim \
    && ./obj_dir/tb_sim \
    || exit 1
